/* Makefile */
# Verilator simulation of the image loader

VERILATOR ?= verilator
TOP       ?= tb_image_loader
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* sources.f */
src/loader_pkg.sv
src/mem_pkg.sv
src/credit_fifo.sv
src/load_fsm.sv
src/load_timer.sv
src/image_ram.sv
src/image_loader_top.sv
testbench/tb_image_loader.sv

/* src/credit_fifo.sv */
// ------------------------------------------------
// Credit FIFO
// Buffers image bytes from the host and returns
// one credit per byte taken by the loader FSM
// ------------------------------------------------

module credit_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic              clk_sys,
	input  logic              reset_key,
	input  logic              push_i,
	input  loader_pkg::byte_t push_data_i,
	input  logic              pop_i,
	output logic              valid_o,
	output loader_pkg::byte_t data_o,
	output logic              credit_o
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	loader_pkg::byte_t mem [FIFO_DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [CNT_W-1:0]  count;
	logic              do_pop;

	// Pointer advance with wrap for any depth
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign valid_o = (count != '0);
	assign data_o  = mem[rd_ptr];
	assign do_pop  = pop_i && valid_o;

	always_ff @(posedge clk_sys) begin
		if (push_i) begin
			mem[wr_ptr] <= push_data_i;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset_key) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			credit_o <= 1'b0;
		end else begin
			// One credit back per byte handed to the FSM
			credit_o <= do_pop;
			if (push_i) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			case ({push_i, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Host sent a byte without holding a credit
	a_push_has_credit: assert property (@(posedge clk_sys) disable iff (reset_key)
		push_i |-> (count != CNT_W'(FIFO_DEPTH)))
		else $error("credit_fifo: byte pushed into a full FIFO");

endmodule

/* src/image_loader_top.sv */
// ------------------------------------------------
// Image loader top level
// Host byte stream with credit flow control into
// the loader FSM, erase pacing, reset stretch and
// the image RAM with a readback port
// ------------------------------------------------

module image_loader_top #(
	parameter int ADDR_W     = 16,
	parameter int ERASE_DIV  = 64,
	parameter int RESET_HOLD = 15,
	parameter int FIFO_DEPTH = 4
) (
	input  logic               clk_sys,
	input  logic               reset_key,
	input  logic               dl_active_i,
	input  logic               byte_valid_i,
	input  loader_pkg::byte_t  byte_data_i,
	output logic               credit_o,
	input  mem_pkg::mem_addr_t rd_addr_i,
	output loader_pkg::byte_t  rd_data_o,
	output logic               sys_reset_o
);

	logic              fifo_valid;
	loader_pkg::byte_t fifo_data;
	logic              pop;
	logic              erase_tick;
	logic              busy;
	mem_pkg::mem_wr_t  mem_wr;

	credit_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_fifo (
		.clk_sys    (clk_sys),
		.reset_key  (reset_key),
		.push_i     (byte_valid_i),
		.push_data_i(byte_data_i),
		.pop_i      (pop),
		.valid_o    (fifo_valid),
		.data_o     (fifo_data),
		.credit_o   (credit_o)
	);

	load_fsm #(
		.ADDR_W(ADDR_W)
	) u_fsm (
		.clk_sys     (clk_sys),
		.reset_key   (reset_key),
		.dl_active_i (dl_active_i),
		.byte_valid_i(fifo_valid),
		.byte_i      (fifo_data),
		.pop_o       (pop),
		.erase_tick_i(erase_tick),
		.busy_o      (busy),
		.wr_o        (mem_wr)
	);

	load_timer #(
		.ERASE_DIV (ERASE_DIV),
		.RESET_HOLD(RESET_HOLD)
	) u_timer (
		.clk_sys     (clk_sys),
		.reset_key   (reset_key),
		.busy_i      (busy),
		.erase_tick_o(erase_tick),
		.sys_reset_o (sys_reset_o)
	);

	image_ram #(
		.ADDR_W(ADDR_W)
	) u_ram (
		.clk_sys  (clk_sys),
		.wr_i     (mem_wr),
		.rd_addr_i(rd_addr_i),
		.rd_data_o(rd_data_o)
	);

endmodule

/* src/image_ram.sv */
// ------------------------------------------------
// Image RAM
// Single clock, one write port from the loader and
// one synchronous read port for readback
// ------------------------------------------------

module image_ram #(
	parameter int ADDR_W = 16
) (
	input  logic               clk_sys,
	input  mem_pkg::mem_wr_t   wr_i,
	input  mem_pkg::mem_addr_t rd_addr_i,
	output loader_pkg::byte_t  rd_data_o
);

	localparam int DEPTH = 2 ** ADDR_W;

	loader_pkg::byte_t mem [DEPTH];

	// Upper address bits fold onto the RAM size
	always_ff @(posedge clk_sys) begin
		if (wr_i.en) begin
			mem[wr_i.addr[ADDR_W-1:0]] <= wr_i.data;
		end
	end

	// Read data one cycle after the address
	always_ff @(posedge clk_sys) begin
		rd_data_o <= mem[rd_addr_i[ADDR_W-1:0]];
	end

endmodule

/* src/load_fsm.sv */
// ------------------------------------------------
// Image loader FSM
// Parses the tape header, writes the jump stub and
// the data bytes, then zero-fills the rest of the
// memory one address per erase tick
// ------------------------------------------------

module load_fsm #(
	parameter int ADDR_W = 16
) (
	input  logic              clk_sys,
	input  logic              reset_key,
	input  logic              dl_active_i,
	input  logic              byte_valid_i,
	input  loader_pkg::byte_t byte_i,
	output logic              pop_o,
	input  logic              erase_tick_i,
	output logic              busy_o,
	output mem_pkg::mem_wr_t  wr_o
);

	loader_pkg::load_state_e state;
	logic [2:0]              hdr_cnt;
	loader_pkg::start_addr_t start_addr;
	mem_pkg::mem_addr_t      data_addr;

	logic [ADDR_W-1:0] erase_addr;
	logic [ADDR_W-1:0] erase_next;
	logic [ADDR_W-1:0] erase_after;
	logic [ADDR_W-1:0] start_wrap;
	logic              erase_done;

	// Registered write port that also holds the last written address
	logic               wr_en;
	mem_pkg::mem_addr_t wr_addr;
	loader_pkg::byte_t  wr_data;
	logic               wr_en_d;
	mem_pkg::mem_addr_t wr_addr_d;
	loader_pkg::byte_t  wr_data_d;

	assign pop_o  = ((state == loader_pkg::HEADER) || (state == loader_pkg::DATA)) &&
		byte_valid_i;
	assign busy_o = (state != loader_pkg::IDLE);
	assign wr_o   = '{en: wr_en, addr: wr_addr, data: wr_data};

	// Erase walks upward with wrap and stops short of the start address
	assign start_wrap  = start_addr[ADDR_W-1:0];
	assign erase_next  = erase_addr + 1'b1;
	assign erase_after = erase_next + 1'b1;
	assign erase_done  = (erase_next == start_wrap) || (erase_after == start_wrap);

	// ------------------------------------------------
	// Next write request
	// ------------------------------------------------
	always_comb begin
		wr_en_d   = 1'b0;
		wr_addr_d = wr_addr;
		wr_data_d = wr_data;
		case (state)
			loader_pkg::HEADER: begin
				if (pop_o) begin
					case (hdr_cnt)
						3'(loader_pkg::HDR_ADDR_HI_POS): begin
							wr_en_d   = 1'b1;
							wr_addr_d = 16'd0;
							wr_data_d = loader_pkg::JMP_OPCODE;
						end
						3'(loader_pkg::HDR_ADDR_LO_POS): begin
							wr_en_d   = 1'b1;
							wr_addr_d = 16'd1;
							wr_data_d = byte_i;
						end
						3'(loader_pkg::HDR_STUB_HI_POS): begin
							wr_en_d   = 1'b1;
							wr_addr_d = 16'd2;
							wr_data_d = start_addr[15:8];
						end
						default: ;
					endcase
				end
			end
			loader_pkg::DATA: begin
				if (pop_o) begin
					wr_en_d   = 1'b1;
					wr_addr_d = data_addr;
					wr_data_d = byte_i;
				end
			end
			loader_pkg::ERASE: begin
				// Stub bytes are never cleared
				if (erase_tick_i && (erase_next != start_wrap) &&
					(erase_next >= ADDR_W'(loader_pkg::STUB_LEN))) begin
					wr_en_d   = 1'b1;
					wr_addr_d = mem_pkg::mem_addr_t'(erase_next);
					wr_data_d = '0;
				end
			end
			default: ;
		endcase
	end

	// ------------------------------------------------
	// State and write control
	// ------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset_key) begin
			state   <= loader_pkg::IDLE;
			hdr_cnt <= '0;
			wr_en   <= 1'b0;
			wr_addr <= '0;
		end else begin
			wr_en   <= wr_en_d;
			wr_addr <= wr_addr_d;
			case (state)
				loader_pkg::IDLE: begin
					hdr_cnt <= '0;
					if (dl_active_i) begin
						state <= loader_pkg::HEADER;
					end
				end
				loader_pkg::HEADER: begin
					if (pop_o) begin
						hdr_cnt <= hdr_cnt + 1'b1;
						if (hdr_cnt == 3'(loader_pkg::HDR_LEN - 1)) begin
							state <= loader_pkg::DATA;
						end
					end else if (!dl_active_i) begin
						state <= loader_pkg::ERASE_ARM;
					end
				end
				loader_pkg::DATA: begin
					if (!pop_o && !dl_active_i) begin
						state <= loader_pkg::ERASE_ARM;
					end
				end
				loader_pkg::ERASE_ARM: state <= loader_pkg::ERASE;
				loader_pkg::ERASE: begin
					if (erase_tick_i && erase_done) begin
						state <= loader_pkg::IDLE;
					end
				end
				default: state <= loader_pkg::IDLE;
			endcase
		end
	end

	// Start address, data pointer and erase pointer
	always_ff @(posedge clk_sys) begin
		wr_data <= wr_data_d;
		if (state == loader_pkg::HEADER && pop_o) begin
			if (hdr_cnt == 3'(loader_pkg::HDR_ADDR_HI_POS)) begin
				start_addr[15:8] <= byte_i;
			end
			if (hdr_cnt == 3'(loader_pkg::HDR_ADDR_LO_POS)) begin
				start_addr[7:0] <= byte_i;
			end
			if (hdr_cnt == 3'(loader_pkg::HDR_LEN - 1)) begin
				data_addr <= start_addr;
			end
		end
		if (state == loader_pkg::DATA && pop_o) begin
			data_addr <= data_addr + 1'b1;
		end
		if (state == loader_pkg::ERASE_ARM) begin
			erase_addr <= wr_addr[ADDR_W-1:0];
		end
		if (state == loader_pkg::ERASE && erase_tick_i) begin
			erase_addr <= erase_next;
		end
	end

	// No write issued while erasing lands in the stub as the RAM decodes it
	a_erase_skips_stub: assert property (@(posedge clk_sys) disable iff (reset_key)
		(state == loader_pkg::ERASE) |=>
		(!wr_en || (wr_addr[ADDR_W-1:0] >= ADDR_W'(loader_pkg::STUB_LEN))))
		else $error("load_fsm: erase write into the jump stub");

endmodule

/* src/load_timer.sv */
// ------------------------------------------------
// Loader timer
// Paces erase writes and stretches the system
// reset past the end of loader activity
// ------------------------------------------------

module load_timer #(
	parameter int ERASE_DIV  = 64,
	parameter int RESET_HOLD = 15
) (
	input  logic clk_sys,
	input  logic reset_key,
	input  logic busy_i,
	output logic erase_tick_o,
	output logic sys_reset_o
);

	localparam int DIV_W  = (ERASE_DIV > 1) ? $clog2(ERASE_DIV) : 1;
	localparam int HOLD_W = (RESET_HOLD > 0) ? $clog2(RESET_HOLD + 1) : 1;

	logic [DIV_W-1:0]  div_cnt;
	logic [HOLD_W-1:0] hold_cnt;

	// One tick every ERASE_DIV cycles
	assign erase_tick_o = (div_cnt == DIV_W'(ERASE_DIV - 1));

	always_ff @(posedge clk_sys) begin
		if (reset_key || erase_tick_o) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// ------------------------------------------------
	// Reset stretch
	// ------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset_key || busy_i) begin
			sys_reset_o <= 1'b1;
			hold_cnt    <= '0;
		end else if (hold_cnt != HOLD_W'(RESET_HOLD)) begin
			hold_cnt <= hold_cnt + 1'b1;
		end else begin
			sys_reset_o <= 1'b0;
		end
	end

endmodule

/* src/loader_pkg.sv */
// ------------------------------------------------
// Image loader definitions
// Tape image byte types, header layout, jump stub
// opcode and the loader FSM state encoding
// ------------------------------------------------

package loader_pkg;

	// One byte of the tape image or of memory
	typedef logic [7:0] byte_t;

	// Start address taken from the header
	typedef logic [15:0] start_addr_t;

	// Loader FSM states
	typedef enum logic [2:0] {
		IDLE,
		HEADER,
		DATA,
		ERASE_ARM,
		ERASE
	} load_state_e;

	// ------------------------------------------------
	// Header layout, bytes 0 and 4 carry nothing used
	// ------------------------------------------------
	localparam int HDR_LEN         = 5;
	localparam int HDR_ADDR_HI_POS = 1;
	localparam int HDR_ADDR_LO_POS = 2;
	localparam int HDR_STUB_HI_POS = 3;

	// Jump stub at address 0, also the protected range
	localparam byte_t JMP_OPCODE = 8'hC3;
	localparam int    STUB_LEN   = 3;

endpackage

/* src/mem_pkg.sv */
// ------------------------------------------------
// Memory port definitions
// Address type and write request shared by the
// loader FSM, the image RAM and the top level
// ------------------------------------------------

package mem_pkg;

	// Full CPU address, the RAM uses the low bits
	typedef logic [15:0] mem_addr_t;

	// One write request per cycle
	typedef struct packed {
		logic              en;
		mem_addr_t         addr;
		loader_pkg::byte_t data;
	} mem_wr_t;

endpackage

/* testbench/image_golden.txt */
# Records: B data | E (end of image) | C addr expected | D (end), values in hex
# Header bytes: ignored, start high, start low, ignored, ignored
# First image, start 0x0200, eight data bytes
B 00 B 02 B 00 B 10 B 20
B 11 B 22 B 33 B 44 B 55 B 66 B 77 B 88
E
C 0000 C3 C 0001 00 C 0002 02
C 0200 11 C 0203 44 C 0207 88
C 0003 00 C 01FF 00 C 0208 00 C 03FF 00
# Second image, start 0x01FE, shorter than the first
B 00 B 01 B FE B 9A B 9B
B A1 B A2 B A3 B A4
E
C 0000 C3 C 0001 FE C 0002 01
C 01FE A1 C 01FF A2 C 0200 A3 C 0201 A4
# Tail of the first image must be gone
C 0202 00 C 0205 00 C 0207 00
C 0003 00 C 01FD 00 C 0300 00
D

/* testbench/tb_image_loader.sv */
// ------------------------------------------------
// Image loader testbench
// Replays tape images from the golden record file
// under credit flow control, then reads memory back
// and checks the jump stub, data, erase and reset
// ------------------------------------------------

module tb_image_loader;

	localparam int ADDR_W     = 10;
	localparam int ERASE_DIV  = 4;
	localparam int RESET_HOLD = 15;
	localparam int FIFO_DEPTH = 4;
	localparam int MEM_SIZE   = 2 ** ADDR_W;

	logic               clk_sys;
	logic               reset_key;
	logic               dl_active_i;
	logic               byte_valid_i;
	loader_pkg::byte_t  byte_data_i;
	logic               credit_o;
	mem_pkg::mem_addr_t rd_addr_i;
	loader_pkg::byte_t  rd_data_o;
	logic               sys_reset_o;

	// Golden records
	logic [7:0]  rec_op[$];
	logic [15:0] rec_addr[$];
	logic [7:0]  rec_data[$];

	int images      = 0;
	int watch_limit = 0;
	int cyc         = 0;
	int last_wr_cyc = 0;
	int sent        = 0;
	int returned    = 0;
	int stall       = 0;

	image_loader_top #(
		.ADDR_W    (ADDR_W),
		.ERASE_DIV (ERASE_DIV),
		.RESET_HOLD(RESET_HOLD),
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_dut (
		.clk_sys     (clk_sys),
		.reset_key   (reset_key),
		.dl_active_i (dl_active_i),
		.byte_valid_i(byte_valid_i),
		.byte_data_i (byte_data_i),
		.credit_o    (credit_o),
		.rd_addr_i   (rd_addr_i),
		.rd_data_o   (rd_data_o),
		.sys_reset_o (sys_reset_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	task automatic stop_on_failure();
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped on first failure");
	endtask

	task automatic check_value(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		if (got !== exp) begin
			$display("[ERROR] time %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
			stop_on_failure();
		end
	endtask

	// ------------------------------------------------
	// Golden file parser that skips '#' comment lines
	// ------------------------------------------------
	task automatic load_golden();
		int          fd;
		int          r;
		int          ch;
		logic [7:0]  op;
		logic [15:0] a;
		logic [7:0]  d;
		bit          done;
		fd   = $fopen("testbench/image_golden.txt", "r");
		done = 1'b0;
		if (fd == 0) begin
			$display("Cannot open the golden record file");
			stop_on_failure();
		end
		while (!done) begin
			a = '0;
			d = '0;
			r = $fscanf(fd, " %c", op);
			if (r != 1) begin
				$display("Golden file ends without a D record");
				stop_on_failure();
			end
			case (op)
				"#": begin
					do begin
						ch = $fgetc(fd);
					end while (ch != 10 && ch != -1);
				end
				"B": r = $fscanf(fd, " %h", d);
				"C": r = $fscanf(fd, " %h %h", a, d);
				"E": images++;
				"D": done = 1'b1;
				default: begin
					$display("Unknown record type in the golden file");
					stop_on_failure();
				end
			endcase
			if (op != "#") begin
				rec_op.push_back(op);
				rec_addr.push_back(a);
				rec_data.push_back(d);
			end
		end
		$fclose(fd);
	endtask

	// Host side sends only while holding a credit
	task automatic send_byte(input logic [7:0] b);
		int gap;
		gap = $urandom_range(0, 2);
		repeat (gap) begin
			@(posedge clk_sys);
			byte_valid_i <= 1'b0;
		end
		do begin
			@(posedge clk_sys);
			byte_valid_i <= 1'b0;
		end while (sent - returned >= FIFO_DEPTH);
		dl_active_i  <= 1'b1;
		byte_valid_i <= 1'b1;
		byte_data_i  <= b;
		sent         <= sent + 1;
	endtask

	task automatic end_download();
		int delay;
		@(posedge clk_sys);
		byte_valid_i <= 1'b0;
		while (returned != sent) begin
			@(posedge clk_sys);
		end
		dl_active_i <= 1'b0;
		@(negedge clk_sys);
		check_value("sys_reset_o", 16'(sys_reset_o), 16'd1);
		while (sys_reset_o) begin
			@(negedge clk_sys);
		end
		// Release counted from the edge where the last write landed
		delay = cyc - last_wr_cyc;
		check_value("sys_reset_o late release", 16'(delay > RESET_HOLD + 1), 16'd0);
	endtask

	task automatic read_back(input logic [15:0] addr, input logic [7:0] exp);
		@(posedge clk_sys);
		byte_valid_i <= 1'b0;
		rd_addr_i    <= addr;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_value("sys_reset_o", 16'(sys_reset_o), 16'd0);
		check_value($sformatf("rd_data_o at 0x%04h", addr), 16'(rd_data_o), 16'(exp));
	endtask

	// ------------------------------------------------
	// Credit and write monitor
	// ------------------------------------------------
	always @(posedge clk_sys) begin
		cyc <= cyc + 1;
		if (credit_o) begin
			returned <= returned + 1;
			if (returned >= sent) begin
				$display("Credit returned with no byte outstanding");
				stop_on_failure();
			end
		end
		if (u_dut.mem_wr.en) begin
			last_wr_cyc <= cyc + 1;
			if (!sys_reset_o) begin
				$display("Memory written while sys_reset_o was low");
				stop_on_failure();
			end
		end
		if (credit_o || sent == returned) begin
			stall <= 0;
		end else begin
			stall <= stall + 1;
		end
		if (stall >= 100) begin
			$display("No credit came back for 100 cycles");
			stop_on_failure();
		end
	end

	// Run limit scales with the number of images
	initial begin
		wait (watch_limit > 0);
		repeat (watch_limit) @(posedge clk_sys);
		$display("Run timed out after %0d cycles", watch_limit);
		stop_on_failure();
	end

	initial begin
		reset_key    = 1'b1;
		dl_active_i  = 1'b0;
		byte_valid_i = 1'b0;
		byte_data_i  = '0;
		rd_addr_i    = '0;
		void'($urandom(32'h5852));
		load_golden();
		watch_limit = 20000 + images * 8 * ERASE_DIV * MEM_SIZE;
		repeat (10) @(posedge clk_sys);
		reset_key <= 1'b0;
		for (int i = 0; i < rec_op.size(); i++) begin
			case (rec_op[i])
				"B": send_byte(rec_data[i]);
				"E": end_download();
				"C": read_back(rec_addr[i], rec_data[i]);
				default: ;
			endcase
		end
		check_value("outstanding credits", 16'(sent - returned), 16'd0);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule
